//--- Makefile
# Verilator build and run for the peripheral interrupt subsystem

VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/cmp_timer.sv
`include "periph_consts.svh"

module cmp_timer (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          sel_i,
    input  logic                          write_i,
    input  logic [`PERIPH_ADDR_W-1:0]     addr_i,
    input  logic [`PERIPH_DATA_W-1:0]     wdata_i,
    output logic [`PERIPH_DATA_W-1:0]     rdata_o,
    output logic                          error_o,
    output logic [`PERIPH_NUM_TIMERS-1:0] irq_o
);
    import periph_pkg::*;

    localparam int STRIDE_SHIFT = $clog2(`PERIPH_TIMER_STRIDE);
    localparam int TIDX_W       = $clog2(`PERIPH_NUM_TIMERS);

    logic [`PERIPH_ADDR_W-1:0]     ofs;
    logic [`PERIPH_ADDR_W-1:0]     blk;
    logic [TIDX_W-1:0]             tidx;
    timer_reg_e                    reg_idx;
    logic                          hit;
    logic                          wr_hit;
    logic [`PERIPH_DATA_W-1:0]     rd_val;

    logic [`PERIPH_NUM_TIMERS-1:0] en_q;
    logic [`PERIPH_NUM_TIMERS-1:0] status_q;
    logic [`PERIPH_NUM_TIMERS-1:0] wr_sel;
    logic [`PERIPH_NUM_TIMERS-1:0] match;
    logic [`PERIPH_DATA_W-1:0]     count_q [`PERIPH_NUM_TIMERS];
    logic [`PERIPH_DATA_W-1:0]     cmp_q   [`PERIPH_NUM_TIMERS];

    // --------------------------------------------------
    // Offset decode
    // --------------------------------------------------
    always_comb begin
        ofs = addr_i;
        ofs[`PERIPH_PLIC_SEL_BIT] = 1'b0;   // Region bit handled by the top
        blk     = ofs >> STRIDE_SHIFT;
        tidx    = blk[TIDX_W-1:0];
        reg_idx = timer_reg_e'(ofs[STRIDE_SHIFT-1:2]);
        hit     = (blk < `PERIPH_ADDR_W'(`PERIPH_NUM_TIMERS)) && (ofs[1:0] == 2'b00);
    end

    assign wr_hit = sel_i && write_i && hit;

    always_comb begin
        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            wr_sel[i] = wr_hit && (tidx == TIDX_W'(i));
            match[i]  = en_q[i] && (count_q[i] == cmp_q[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
                en_q[i]     <= 1'b0;
                status_q[i] <= 1'b0;
                count_q[i]  <= '0;
                cmp_q[i]    <= '0;
            end
        end else begin
            for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
                if (wr_sel[i] && reg_idx == TMR_CTRL) en_q[i] <= wdata_i[0];
                if (wr_sel[i] && reg_idx == TMR_CMP) cmp_q[i] <= wdata_i;
                if (wr_sel[i] && reg_idx == TMR_COUNT) begin
                    count_q[i] <= wdata_i;           // Software load
                end else if (match[i]) begin
                    count_q[i] <= '0;
                end else if (en_q[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
                // Match wins over a clear in the same cycle
                if (match[i]) begin
                    status_q[i] <= 1'b1;
                end else if (wr_sel[i] && reg_idx == TMR_STATUS && wdata_i[0]) begin
                    status_q[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        case (reg_idx)
            TMR_CTRL:   rd_val = `PERIPH_DATA_W'(en_q[tidx]);
            TMR_COUNT:  rd_val = count_q[tidx];
            TMR_CMP:    rd_val = cmp_q[tidx];
            default:    rd_val = `PERIPH_DATA_W'(status_q[tidx]);
        endcase
    end

    // Response one cycle after the select, zero otherwise
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_o <= '0;
            error_o <= 1'b0;
        end else begin
            rdata_o <= (sel_i && !write_i && hit) ? rd_val : '0;
            error_o <= sel_i && !hit;
        end
    end

    assign irq_o = status_q;

    for (genvar i = 0; i < `PERIPH_NUM_TIMERS; i++) begin : g_chk
        a_status_needs_en: assert property (@(posedge clk_i) disable iff (rst_i)
            $rose(status_q[i]) |-> $past(en_q[i]));
    end

endmodule

//--- design/irq_gateway.sv
`include "periph_consts.svh"

module irq_gateway (
    input  logic                clk_i,
    input  logic                rst_i,
    input  periph_pkg::src_vec_t src_i,
    input  logic                claim_i,
    input  periph_pkg::src_id_t  claim_id_i,
    input  logic                complete_i,
    input  periph_pkg::src_id_t  complete_id_i,
    output periph_pkg::src_vec_t pending_o
);
    import periph_pkg::*;

    gw_state_e state_q [`PERIPH_NUM_SRC];
    src_vec_t  claim_hit;
    src_vec_t  complete_hit;

    // --------------------------------------------------
    // Per-source strobe decode
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
            claim_hit[i]    = claim_i && (claim_id_i == src_id_t'(i));
            complete_hit[i] = complete_i && (complete_id_i == src_id_t'(i));
        end
    end

    // Each level source holds one request until claimed
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
                state_q[i] <= GW_IDLE;
            end
        end else begin
            for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
                case (state_q[i])
                    GW_IDLE: begin
                        if (src_i[i]) state_q[i] <= GW_PENDING;
                    end
                    GW_PENDING: begin
                        if (claim_hit[i]) state_q[i] <= GW_IN_SERVICE;
                    end
                    GW_IN_SERVICE: begin
                        // Line still high pends again on the next edge
                        if (complete_hit[i]) state_q[i] <= GW_IDLE;
                    end
                    default: state_q[i] <= GW_IDLE;
                endcase
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
            pending_o[i] = (state_q[i] == GW_PENDING);
        end
    end

    // Target may only claim what this gateway offers
    a_claim_pending: assert property (@(posedge clk_i) disable iff (rst_i)
        claim_i |-> pending_o[claim_id_i]);

endmodule

//--- design/irq_target.sv
`include "periph_consts.svh"

module irq_target (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      sel_i,
    input  logic                      write_i,
    input  logic [`PERIPH_ADDR_W-1:0] addr_i,
    input  logic [`PERIPH_DATA_W-1:0] wdata_i,
    input  periph_pkg::src_vec_t      pending_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o,
    output logic                      error_o,
    output logic                      claim_o,
    output periph_pkg::src_id_t       claim_id_o,
    output logic                      complete_o,
    output periph_pkg::src_id_t       complete_id_o,
    output logic                      irq_o
);
    import periph_pkg::*;

    logic [`PERIPH_ADDR_W-1:0] ofs;
    logic [`PERIPH_ADDR_W-1:0] prio_rel;
    src_id_t                   prio_idx;
    logic                      prio_hit;
    logic                      en_hit;
    logic                      thr_hit;
    logic                      claim_hit;
    logic                      hit;
    logic [`PERIPH_DATA_W-1:0] rd_val;

    prio_t    prio_q [`PERIPH_NUM_SRC];
    src_vec_t en_q;
    prio_t    thresh_q;
    src_id_t  best_id;
    prio_t    best_prio;

    // --------------------------------------------------
    // Offset decode
    // --------------------------------------------------
    always_comb begin
        ofs = addr_i;
        ofs[`PERIPH_PLIC_SEL_BIT] = 1'b0;
        prio_rel  = ofs - `PERIPH_PRIO_BASE;   // Wraps high below the base
        prio_idx  = src_id_t'(prio_rel[`PERIPH_ADDR_W-1:2]);
        prio_hit  = (prio_rel < `PERIPH_ADDR_W'(4 * `PERIPH_NUM_SRC))
                    && (ofs[1:0] == 2'b00);
        en_hit    = (ofs == `PERIPH_ENABLE_OFS);
        thr_hit   = (ofs == `PERIPH_THRESH_OFS);
        claim_hit = (ofs == `PERIPH_CLAIM_OFS);
        hit       = prio_hit || en_hit || thr_hit || claim_hit;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
                prio_q[i] <= '0;
            end
            en_q     <= '0;
            thresh_q <= '0;
        end else if (sel_i && write_i) begin
            if (prio_hit) prio_q[prio_idx] <= wdata_i[`PERIPH_PRIO_W-1:0];
            if (en_hit) en_q <= wdata_i[`PERIPH_NUM_SRC-1:0];
            if (thr_hit) thresh_q <= wdata_i[`PERIPH_PRIO_W-1:0];
        end
    end

    // --------------------------------------------------
    // Highest priority above threshold
    // --------------------------------------------------
    always_comb begin
        best_id   = '0;
        best_prio = thresh_q;
        // Strict compare keeps the lowest id on a tie
        for (int i = 1; i < `PERIPH_NUM_SRC; i++) begin
            if (pending_i[i] && en_q[i] && (prio_q[i] > best_prio)) begin
                best_id   = src_id_t'(i);
                best_prio = prio_q[i];
            end
        end
    end

    assign irq_o = (best_id != '0);

    // Strobes act on the edge that registers the response
    assign claim_o       = sel_i && !write_i && claim_hit && irq_o;
    assign claim_id_o    = best_id;
    assign complete_o    = sel_i && write_i && claim_hit;
    assign complete_id_o = wdata_i[2:0];

    always_comb begin
        rd_val = '0;
        if (prio_hit) begin
            rd_val = `PERIPH_DATA_W'(prio_q[prio_idx]);
        end else if (en_hit) begin
            rd_val = `PERIPH_DATA_W'(en_q);
        end else if (thr_hit) begin
            rd_val = `PERIPH_DATA_W'(thresh_q);
        end else if (claim_hit) begin
            rd_val = `PERIPH_DATA_W'(best_id);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_o <= '0;
            error_o <= 1'b0;
        end else begin
            rdata_o <= (sel_i && !write_i && hit) ? rd_val : '0;
            error_o <= sel_i && !hit;
        end
    end

    // No qualifying source outranks the selected id
    for (genvar i = 1; i < `PERIPH_NUM_SRC; i++) begin : g_chk
        a_best_selected: assert property (@(posedge clk_i) disable iff (rst_i)
            (pending_i[i] && en_q[i] && (prio_q[i] > thresh_q)) |->
                irq_o && ((prio_q[best_id] > prio_q[i])
                          || ((prio_q[best_id] == prio_q[i])
                              && (best_id <= src_id_t'(i)))));
    end

endmodule

//--- design/periph_consts.svh
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Sizes
`define PERIPH_NUM_SRC      8      // Id 0 means no interrupt
`define PERIPH_NUM_TIMERS   2
`define PERIPH_PRIO_W       3
`define PERIPH_ADDR_W       12     // Byte address
`define PERIPH_DATA_W       32

// Selects the controller when set and the timers when clear
`define PERIPH_PLIC_SEL_BIT 11

// --------------------------------------------------
// Controller register map
// --------------------------------------------------
`define PERIPH_PRIO_BASE    12'h000  // One word per id
`define PERIPH_ENABLE_OFS   12'h080
`define PERIPH_THRESH_OFS   12'h090
`define PERIPH_CLAIM_OFS    12'h094

// Timer blocks
`define PERIPH_TIMER_STRIDE 12'h010

`endif

//--- design/periph_pkg.sv
`include "periph_consts.svh"

package periph_pkg;

    // Per-source gateway state
    typedef enum logic [1:0] {
        GW_IDLE       = 2'd0,
        GW_PENDING    = 2'd1,
        GW_IN_SERVICE = 2'd2
    } gw_state_e;

    // Word index inside one timer block
    typedef enum logic [1:0] {
        TMR_CTRL   = 2'd0,  // 0x0
        TMR_COUNT  = 2'd1,  // 0x4
        TMR_CMP    = 2'd2,  // 0x8
        TMR_STATUS = 2'd3   // 0xC
    } timer_reg_e;

    // --------------------------------------------------
    // Shared vector types
    // --------------------------------------------------
    typedef logic [`PERIPH_NUM_SRC-1:0] src_vec_t;
    typedef logic [2:0]                 src_id_t;
    typedef logic [`PERIPH_PRIO_W-1:0]  prio_t;

endpackage

//--- design/periph_subsys.sv
`include "periph_consts.svh"

module periph_subsys (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      req_valid_i,
    input  logic                      req_write_i,
    input  logic [`PERIPH_ADDR_W-1:0] req_addr_i,
    input  logic [`PERIPH_DATA_W-1:0] req_wdata_i,
    input  logic [4:0]                ext_irq_i,
    output logic                      resp_ready_o,
    output logic [`PERIPH_DATA_W-1:0] resp_rdata_o,
    output logic                      resp_error_o,
    output logic                      irq_o
);
    import periph_pkg::*;

    logic                          tmr_sel;
    logic                          plic_sel;
    logic                          resp_valid_q;
    logic                          region_q;     // 1 for controller

    logic [`PERIPH_NUM_TIMERS-1:0] tmr_irq;
    logic [`PERIPH_DATA_W-1:0]     tmr_rdata;
    logic                          tmr_error;
    logic [`PERIPH_DATA_W-1:0]     plic_rdata;
    logic                          plic_error;

    src_vec_t irq_src;
    src_vec_t pending;
    logic     claim;
    src_id_t  claim_id;
    logic     complete;
    src_id_t  complete_id;

    // --------------------------------------------------
    // Source map
    // --------------------------------------------------
    assign irq_src = {ext_irq_i, tmr_irq, 1'b0};   // Id 0 never requests

    // --------------------------------------------------
    // Region decode and response path
    // --------------------------------------------------
    assign plic_sel = req_valid_i && req_addr_i[`PERIPH_PLIC_SEL_BIT];
    assign tmr_sel  = req_valid_i && !req_addr_i[`PERIPH_PLIC_SEL_BIT];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_valid_q <= 1'b0;
            region_q     <= 1'b0;
        end else begin
            resp_valid_q <= req_valid_i;
            region_q     <= req_addr_i[`PERIPH_PLIC_SEL_BIT];
        end
    end

    assign resp_ready_o = resp_valid_q;
    assign resp_rdata_o = region_q ? plic_rdata : tmr_rdata;
    assign resp_error_o = region_q ? plic_error : tmr_error;

    cmp_timer i_timer (
        .clk_i   ( clk_i       ),
        .rst_i   ( rst_i       ),
        .sel_i   ( tmr_sel     ),
        .write_i ( req_write_i ),
        .addr_i  ( req_addr_i  ),
        .wdata_i ( req_wdata_i ),
        .rdata_o ( tmr_rdata   ),
        .error_o ( tmr_error   ),
        .irq_o   ( tmr_irq     )
    );

    irq_gateway i_gateway (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .src_i         ( irq_src     ),
        .claim_i       ( claim       ),
        .claim_id_i    ( claim_id    ),
        .complete_i    ( complete    ),
        .complete_id_i ( complete_id ),
        .pending_o     ( pending     )
    );

    irq_target i_target (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .sel_i         ( plic_sel    ),
        .write_i       ( req_write_i ),
        .addr_i        ( req_addr_i  ),
        .wdata_i       ( req_wdata_i ),
        .pending_i     ( pending     ),
        .rdata_o       ( plic_rdata  ),
        .error_o       ( plic_error  ),
        .claim_o       ( claim       ),
        .claim_id_o    ( claim_id    ),
        .complete_o    ( complete    ),
        .complete_id_o ( complete_id ),
        .irq_o         ( irq_o       )
    );

endmodule

//--- filelist.f
+incdir+design
design/periph_pkg.sv
design/cmp_timer.sv
design/irq_gateway.sv
design/irq_target.sv
design/periph_subsys.sv
tb/tb_clkgen.sv
tb/tb_periph.sv

//--- tb/tb_clkgen.sv
module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held over two rising edges
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

//--- tb/tb_periph.sv
`include "periph_consts.svh"

module tb_periph;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          TIMEOUT_CYCLES = 5000;  // Around ten times the full run
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
    localparam logic [31:0] CMP_N          = 32'd20;
    localparam logic [11:0] PLIC_BASE      = 12'(1 << `PERIPH_PLIC_SEL_BIT);
    localparam logic [11:0] ENABLE_ADDR    = PLIC_BASE | `PERIPH_ENABLE_OFS;
    localparam logic [11:0] THRESH_ADDR    = PLIC_BASE | `PERIPH_THRESH_OFS;
    localparam logic [11:0] CLAIM_ADDR     = PLIC_BASE | `PERIPH_CLAIM_OFS;
    // Word offsets inside one timer block
    localparam logic [11:0] T_CTRL   = 12'h0;
    localparam logic [11:0] T_COUNT  = 12'h4;
    localparam logic [11:0] T_CMP    = 12'h8;
    localparam logic [11:0] T_STATUS = 12'hc;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_write;
    logic [11:0] req_addr;
    logic [31:0] req_wdata;
    logic [4:0]  ext_irq;
    logic        resp_ready;
    logic [31:0] resp_rdata;
    logic        resp_error;
    logic        irq;

    // Reference model of the controller state
    logic [2:0]  m_prio [8];
    logic [7:0]  m_en;
    logic [2:0]  m_thresh;
    logic [7:0]  m_active;      // Gateway pending per id
    logic [31:0] lfsr_q;
    int          cycles = 0;

    tb_clkgen i_clkgen (
        .clk_o ( clk ),
        .rst_o ( rst )
    );

    periph_subsys uut (
        .clk_i        ( clk        ),
        .rst_i        ( rst        ),
        .req_valid_i  ( req_valid  ),
        .req_write_i  ( req_write  ),
        .req_addr_i   ( req_addr   ),
        .req_wdata_i  ( req_wdata  ),
        .ext_irq_i    ( ext_irq    ),
        .resp_ready_o ( resp_ready ),
        .resp_rdata_o ( resp_rdata ),
        .resp_error_o ( resp_error ),
        .irq_o        ( irq        )
    );

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic stop_on_error();
        $display("=== FAIL ===");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_max(input string name, input logic [31:0] got, input logic [31:0] lim);
        assert (got <= lim) else begin
            $display("CHECK FAILED t=%0t %s got=0x%0h max=0x%0h", $time, name, got, lim);
            stop_on_error();
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            $display("Error at t=%0t: %s", $time, msg);
            stop_on_error();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            stop_on_error();
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_q[0]) lfsr_q = (lfsr_q >> 1) ^ LFSR_TAPS;
            else lfsr_q = lfsr_q >> 1;
            val = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    function automatic logic [11:0] prio_addr(input int id);
        return PLIC_BASE + `PERIPH_PRIO_BASE + 12'(id * 4);
    endfunction

    function automatic logic [11:0] tmr_addr(input int t, input logic [11:0] ofs);
        return 12'(t) * `PERIPH_TIMER_STRIDE + ofs;
    endfunction

    // --------------------------------------------------
    // Bus access
    // --------------------------------------------------
    task automatic bus_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= wdata;
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        check_true(resp_ready, "no response one cycle after the request");
        rdata = resp_rdata;
        err   = resp_error;
    endtask

    task automatic bus_write(input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] d;
        logic        e;
        bus_access(1'b1, addr, wdata, d, e);
        check_eq("resp_error_o", 32'(e), 32'd0);
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] d;
        logic        e;
        bus_access(1'b0, addr, '0, d, e);
        check_eq("resp_error_o", 32'(e), 32'd0);
        check_eq({"resp_rdata_o ", name}, d, exp);
    endtask

    // Two reads on consecutive cycles
    task automatic read_pair(input logic [11:0] a0, input logic [11:0] a1,
                             output logic [31:0] d0, output logic e0,
                             output logic [31:0] d1, output logic e1);
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= 1'b0;
        req_addr  <= a0;
        @(posedge clk);
        req_addr  <= a1;
        @(negedge clk);
        check_true(resp_ready, "first back-to-back response missing");
        d0 = resp_rdata;
        e0 = resp_error;
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        check_true(resp_ready, "second back-to-back response missing");
        d1 = resp_rdata;
        e1 = resp_error;
        @(negedge clk);
        check_true(!resp_ready, "response pulse without a request");
    endtask

    task automatic set_ext(input logic [4:0] lines);
        @(posedge clk);
        ext_irq <= lines;
    endtask

    task automatic set_prio(input int id, input logic [2:0] p);
        bus_write(prio_addr(id), 32'(p));
        m_prio[id] = p;
    endtask

    task automatic set_enable(input logic [7:0] mask);
        bus_write(ENABLE_ADDR, 32'(mask));
        m_en = mask;
    endtask

    task automatic set_thresh(input logic [2:0] t);
        bus_write(THRESH_ADDR, 32'(t));
        m_thresh = t;
    endtask

    // Highest priority above threshold with ties to the lowest id
    function automatic logic [2:0] pick_id();
        logic [2:0] best;
        logic [2:0] best_p;
        best   = '0;
        best_p = m_thresh;
        for (int i = 1; i < 8; i++) begin
            if (m_active[i] && m_en[i] && m_prio[i] > best_p) begin
                best   = 3'(i);
                best_p = m_prio[i];
            end
        end
        return best;
    endfunction

    // Claim, drop the line and complete until nothing qualifies
    task automatic serve_all(input string tag);
        logic [2:0] exp_id;
        for (int n = 0; n < 8; n++) begin
            exp_id = pick_id();
            check_eq({"irq_o ", tag}, 32'(irq), 32'(exp_id != 3'd0));
            read_check(CLAIM_ADDR, 32'(exp_id), {"claim ", tag});
            if (exp_id == 3'd0) break;
            m_active[exp_id] = 1'b0;
            if (exp_id >= 3'd3) begin
                @(posedge clk);
                ext_irq[exp_id - 3'd3] <= 1'b0;
            end
            bus_write(CLAIM_ADDR, 32'(exp_id));
        end
    endtask

    task automatic drain();
        set_ext(5'b0);
        set_thresh(3'd0);
        for (int id = 1; id < 8; id++) set_prio(id, 3'd1);
        set_enable(8'hfe);
        serve_all("drain");
        for (int id = 1; id < 8; id++) set_prio(id, 3'd0);
        set_enable(8'h00);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_reset_readback();
        logic [31:0] d0;
        logic [31:0] d1;
        logic        e0;
        logic        e1;
        check_eq("irq_o", 32'(irq), 32'd0);
        check_eq("resp_ready_o", 32'(resp_ready), 32'd0);
        for (int id = 1; id < 8; id++) read_check(prio_addr(id), 32'd0, "prio reset");
        read_check(ENABLE_ADDR, 32'd0, "enable reset");
        read_check(THRESH_ADDR, 32'd0, "thresh reset");
        read_check(CLAIM_ADDR, 32'd0, "claim reset");
        for (int t = 0; t < 2; t++) begin
            read_check(tmr_addr(t, T_CTRL), 32'd0, "timer ctrl reset");
            read_check(tmr_addr(t, T_COUNT), 32'd0, "timer count reset");
            read_check(tmr_addr(t, T_CMP), 32'd0, "timer cmp reset");
            read_check(tmr_addr(t, T_STATUS), 32'd0, "timer status reset");
        end
        for (int id = 1; id < 8; id++) set_prio(id, 3'(rand_bits(3)));
        for (int id = 1; id < 8; id++) read_check(prio_addr(id), 32'(m_prio[id]), "prio");
        set_enable(8'ha4);
        read_check(ENABLE_ADDR, 32'h0000_00a4, "enable");
        set_thresh(3'd5);
        read_check(THRESH_ADDR, 32'd5, "thresh");
        bus_write(tmr_addr(1, T_CMP), 32'h0001_2345);
        read_check(tmr_addr(1, T_CMP), 32'h0001_2345, "timer 1 cmp");

        // Unmapped offsets in both regions
        bus_access(1'b0, PLIC_BASE | 12'h084, '0, d0, e0);
        check_eq("resp_error_o", 32'(e0), 32'd1);
        check_eq("resp_rdata_o", d0, 32'd0);
        bus_access(1'b0, 12'h020, '0, d0, e0);
        check_eq("resp_error_o", 32'(e0), 32'd1);
        check_eq("resp_rdata_o", d0, 32'd0);
        bus_access(1'b1, PLIC_BASE | 12'h0a0, 32'd7, d0, e0);
        check_eq("resp_error_o", 32'(e0), 32'd1);
        read_check(THRESH_ADDR, 32'd5, "thresh after bad write");

        read_pair(prio_addr(3), tmr_addr(1, T_CMP), d0, e0, d1, e1);
        check_eq("resp_error_o", 32'(e0), 32'd0);
        check_eq("resp_rdata_o prio[3]", d0, 32'(m_prio[3]));
        check_eq("resp_error_o", 32'(e1), 32'd0);
        check_eq("resp_rdata_o timer 1 cmp", d1, 32'h0001_2345);

        bus_write(tmr_addr(1, T_CMP), 32'd0);
        for (int id = 1; id < 8; id++) set_prio(id, 3'd0);
        set_enable(8'h00);
        set_thresh(3'd0);
    endtask

    task automatic test_timer_match();
        logic [31:0] count;
        logic [31:0] status;
        logic        err;
        int          polls;
        status = '0;
        polls  = 0;
        bus_write(tmr_addr(0, T_CMP), CMP_N);
        bus_write(tmr_addr(0, T_CTRL), 32'd1);
        while (status != 32'd1) begin
            bus_access(1'b0, tmr_addr(0, T_COUNT), '0, count, err);
            check_eq("resp_error_o", 32'(err), 32'd0);
            check_max("resp_rdata_o timer 0 count", count, CMP_N);
            bus_access(1'b0, tmr_addr(0, T_STATUS), '0, status, err);
            check_eq("resp_error_o", 32'(err), 32'd0);
            polls++;
            check_true(polls < 50, "timer 0 status never set");
        end
        m_active[1] = 1'b1;
        check_eq("irq_o at priority 0", 32'(irq), 32'd0);
        set_prio(1, 3'd1);
        set_enable(8'h02);
        check_eq("irq_o timer", 32'(irq), 32'd1);
        read_check(CLAIM_ADDR, 32'd1, "claim timer");
        m_active[1] = 1'b0;
        check_eq("irq_o in service", 32'(irq), 32'd0);

        bus_write(tmr_addr(0, T_CTRL), 32'd0);
        bus_write(tmr_addr(0, T_STATUS), 32'd1);
        read_check(tmr_addr(0, T_STATUS), 32'd0, "timer 0 status cleared");
        bus_write(CLAIM_ADDR, 32'd1);
        check_eq("irq_o after complete", 32'(irq), 32'd0);
        @(negedge clk);
        check_eq("irq_o after complete", 32'(irq), 32'd0);
        read_check(CLAIM_ADDR, 32'd0, "claim empty");
        set_prio(1, 3'd0);
        set_enable(8'h00);
        bus_write(tmr_addr(0, T_CMP), 32'd0);
    endtask

    task automatic test_arbitration();
        set_ext(5'h1f);
        m_active = m_active | 8'hf8;
        for (int id = 3; id < 8; id++) set_prio(id, 3'(rand_bits(3)));
        set_thresh(3'(rand_bits(2)));
        set_enable(8'hf8);
        serve_all("arbitration");
        drain();
    endtask

    task automatic test_claim_complete();
        set_thresh(3'd0);
        set_prio(3, 3'd4);
        set_enable(8'h08);
        set_ext(5'b00001);
        @(negedge clk);
        check_eq("irq_o before pend", 32'(irq), 32'd0);
        @(negedge clk);
        check_eq("irq_o one cycle after source", 32'(irq), 32'd1);
        m_active[3] = 1'b1;
        read_check(CLAIM_ADDR, 32'd3, "claim id 3");
        m_active[3] = 1'b0;
        repeat (3) begin
            check_eq("irq_o in service", 32'(irq), 32'd0);
            read_check(CLAIM_ADDR, 32'd0, "claim while in service");
        end
        bus_write(CLAIM_ADDR, 32'd3);
        check_eq("irq_o on complete", 32'(irq), 32'd0);
        @(negedge clk);
        check_eq("irq_o re-pend", 32'(irq), 32'd1);
        m_active[3] = 1'b1;
        serve_all("claim/complete");
        drain();
    endtask

    task automatic test_enable_mask();
        set_ext(5'h1f);
        m_active = m_active | 8'hf8;
        set_thresh(3'd0);
        set_prio(3, 3'd2);
        set_prio(4, 3'd2);
        set_prio(5, 3'd7);
        set_prio(6, 3'd2);
        set_prio(7, 3'd7);
        set_enable(8'h58);      // Ids 3, 4 and 6
        serve_all("enable mask");
        repeat (10) begin
            @(negedge clk);
            check_eq("irq_o masked", 32'(irq), 32'd0);
        end
        drain();
    endtask

    initial begin
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        ext_irq   = '0;
        lfsr_q    = 32'hfd31;
        m_en      = '0;
        m_thresh  = '0;
        m_active  = '0;
        for (int i = 0; i < 8; i++) m_prio[i] = '0;

        wait (rst == 1'b0);
        @(negedge clk);
        test_reset_readback();
        test_timer_match();
        test_arbitration();
        test_claim_complete();
        test_enable_mask();
        $display("=== PASS ===");
        $finish;
    end

endmodule
